// File: source/alu_config.svh
// fixed widths for a 32-bit word split into four byte lanes, changing one alone breaks the lane logic
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// data word width
`define ALU_XLEN 32

// narrowest lane, one byte
`define ALU_LANE_W 8

// number of byte lanes in a word
`define ALU_LANES 4

// bit-count result width, wide enough to hold 32
`define ALU_CNT_W 6

`endif

// File: source/alu_op_pkg.sv
// opcode and lane-mode encodings seen at the ALU boundary, mode code 2'b01 is reserved
`default_nettype none

package alu_op_pkg;

  // kept opcodes, grouped by function in the upper bits
  typedef enum logic [5:0] {
    ALU_ADD   = 6'h00,
    ALU_SUB   = 6'h01,
    ALU_AND   = 6'h04,
    ALU_OR    = 6'h05,
    ALU_XOR   = 6'h06,
    ALU_SLL   = 6'h08,
    ALU_SRL   = 6'h09,
    ALU_SRA   = 6'h0a,
    // per-lane compares
    ALU_EQ    = 6'h10,
    ALU_NE    = 6'h11,
    ALU_GTS   = 6'h12,
    ALU_GTU   = 6'h13,
    ALU_GES   = 6'h14,
    ALU_GEU   = 6'h15,
    ALU_LTS   = 6'h16,
    ALU_LTU   = 6'h17,
    ALU_LES   = 6'h18,
    ALU_LEU   = 6'h19,
    // scalar set-less-than, result in bit 0
    ALU_SLTS  = 6'h1a,
    ALU_SLTU  = 6'h1b,
    ALU_SLETS = 6'h1c,
    ALU_SLETU = 6'h1d,
    ALU_MIN   = 6'h20,
    ALU_MINU  = 6'h21,
    ALU_MAX   = 6'h22,
    ALU_MAXU  = 6'h23,
    ALU_ABS   = 6'h24,
    // bit counts work on the whole word only
    ALU_FF1   = 6'h28,
    ALU_FL1   = 6'h29,
    ALU_CNT   = 6'h2a,
    ALU_CLB   = 6'h2b
  } alu_op_e;

  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

endpackage

`default_nettype wire

// File: source/alu_ctrl_pkg.sv
// decoded control passed from decode to execute and result, never seen outside the ALU
`default_nettype none

package alu_ctrl_pkg;

  // left shifts reuse the right shifter on a bit-reversed operand
  typedef enum logic [1:0] {
    SH_LEFT        = 2'd0,
    SH_RIGHT_LOG   = 2'd1,
    SH_RIGHT_ARITH = 2'd2
  } shift_kind_e;

  // relation applied to the lane equal and greater flags
  typedef enum logic [2:0] {
    CMP_EQ = 3'd0,
    CMP_NE = 3'd1,
    CMP_GT = 3'd2,
    CMP_GE = 3'd3,
    CMP_LT = 3'd4,
    CMP_LE = 3'd5
  } cmp_kind_e;

  typedef enum logic [1:0] {
    BC_FF1 = 2'd0,
    BC_FL1 = 2'd1,
    BC_CNT = 2'd2,
    BC_CLB = 2'd3
  } bitcnt_kind_e;

  // final result class picked by the result mux
  typedef enum logic [3:0] {
    RES_AND        = 4'd0,
    RES_OR         = 4'd1,
    RES_XOR        = 4'd2,
    RES_ADD        = 4'd3,
    RES_SHIFT      = 4'd4,
    RES_CMP_VEC    = 4'd5,
    RES_CMP_SCALAR = 4'd6,
    RES_MINMAX     = 4'd7,
    RES_BITCNT     = 4'd8
  } res_sel_e;

endpackage

`default_nettype wire

// File: source/alu_bitcount.sv
// bit counts act on the full 32-bit operand regardless of lane mode
`timescale 1ns/1ps
`default_nettype none
`include "alu_config.svh"

module alu_bitcount (
  input  logic [`ALU_XLEN-1:0]       operand_a_i,
  input  alu_ctrl_pkg::bitcnt_kind_e bitcnt_kind_i,
  output logic [`ALU_CNT_W-1:0]      bitcnt_o
);
  import alu_ctrl_pkg::*;

  // bit index width, one less than the count width
  localparam int unsigned IDX_W = `ALU_CNT_W - 1;

  logic [`ALU_XLEN-1:0]  a_rev;
  logic [`ALU_XLEN-1:0]  ff_in;
  logic [`ALU_CNT_W-1:0] pop_cnt;
  logic [IDX_W-1:0]      ff_idx;
  logic                  no_ones;

  for (genvar i = 0; i < `ALU_XLEN; i++) begin : g_rev
    assign a_rev[i] = operand_a_i[`ALU_XLEN-1-i];
  end

  // FL1 and CLB search from the msb, so they look at the reversed word
  // negative CLB operands are inverted to count leading ones as zeros
  always_comb begin
    case (bitcnt_kind_i)
      BC_FF1:  ff_in = operand_a_i;
      BC_CLB:  ff_in = operand_a_i[`ALU_XLEN-1] ? ~a_rev : a_rev;
      default: ff_in = a_rev;
    endcase
  end

  always_comb begin
    pop_cnt = '0;
    for (int i = 0; i < `ALU_XLEN; i++) begin
      pop_cnt = pop_cnt + `ALU_CNT_W'(operand_a_i[i]);
    end
  end

  // downward scan so the lowest set bit wins
  always_comb begin
    ff_idx = '0;
    for (int i = `ALU_XLEN - 1; i >= 0; i--) begin
      if (ff_in[i]) ff_idx = IDX_W'(i);
    end
  end

  assign no_ones = ~|ff_in;

  always_comb begin
    case (bitcnt_kind_i)
      BC_FF1: bitcnt_o = no_ones ? `ALU_CNT_W'(`ALU_XLEN) : {1'b0, ff_idx};
      BC_FL1: bitcnt_o = no_ones ? `ALU_CNT_W'(`ALU_XLEN) : {1'b0, 5'd31 - ff_idx};
      BC_CLB: begin
        // zero gives 0 and all ones gives 31
        if (no_ones) bitcnt_o = operand_a_i[`ALU_XLEN-1] ? 6'd31 : 6'd0;
        else         bitcnt_o = {1'b0, ff_idx - 5'd1};
      end
      default: bitcnt_o = pop_cnt;
    endcase
  end

endmodule

`default_nettype wire

// File: source/alu_decode.sv
// purely combinational decode, the reserved lane mode is handled as 32-bit mode
`timescale 1ns/1ps
`default_nettype none
`include "alu_config.svh"

module alu_decode (
  input  alu_op_pkg::alu_op_e        operator_i,
  input  alu_op_pkg::vec_mode_e      vector_mode_i,
  output logic                       adder_negate_o,
  output logic [`ALU_LANES-1:0]      lane_break_o,
  output alu_ctrl_pkg::shift_kind_e  shift_kind_o,
  output logic [`ALU_LANES-1:0]      cmp_signed_o,
  output alu_ctrl_pkg::cmp_kind_e    cmp_kind_o,
  output logic                       do_min_o,
  output logic                       do_abs_o,
  output alu_ctrl_pkg::bitcnt_kind_e bitcnt_kind_o,
  output alu_ctrl_pkg::res_sel_e     res_sel_o
);
  import alu_op_pkg::*;
  import alu_ctrl_pkg::*;

  logic                  op_signed;
  // top byte of every lane, carries the sign
  logic [`ALU_LANES-1:0] lane_top;

  // abs is computed as 0 - A on the adder
  assign adder_negate_o = operator_i inside {ALU_SUB, ALU_ABS};
  assign do_min_o       = operator_i inside {ALU_MIN, ALU_MINU};
  assign do_abs_o       = (operator_i == ALU_ABS);

  assign op_signed = operator_i inside {ALU_GTS, ALU_GES, ALU_LTS, ALU_LES, ALU_SLTS,
                                        ALU_SLETS, ALU_MIN, ALU_MAX, ALU_ABS};

  // byte 0 always starts a lane
  always_comb begin
    case (vector_mode_i)
      VEC_MODE16: begin
        lane_break_o = 4'b0101;
        lane_top     = 4'b1010;
      end
      VEC_MODE8: begin
        lane_break_o = 4'b1111;
        lane_top     = 4'b1111;
      end
      default: begin
        lane_break_o = 4'b0001;
        lane_top     = 4'b1000;
      end
    endcase
  end

  assign cmp_signed_o = op_signed ? lane_top : '0;

  always_comb begin
    shift_kind_o  = SH_RIGHT_LOG;
    cmp_kind_o    = CMP_EQ;
    bitcnt_kind_o = BC_CNT;
    res_sel_o     = RES_AND;
    case (operator_i)
      ALU_OR:  res_sel_o = RES_OR;
      ALU_XOR: res_sel_o = RES_XOR;
      ALU_ADD, ALU_SUB: res_sel_o = RES_ADD;
      ALU_SLL, ALU_SRL, ALU_SRA: begin
        res_sel_o = RES_SHIFT;
        if (operator_i == ALU_SLL) shift_kind_o = SH_LEFT;
        if (operator_i == ALU_SRA) shift_kind_o = SH_RIGHT_ARITH;
      end
      ALU_EQ:  res_sel_o = RES_CMP_VEC;
      ALU_NE: begin
        cmp_kind_o = CMP_NE;
        res_sel_o  = RES_CMP_VEC;
      end
      ALU_GTS, ALU_GTU: begin
        cmp_kind_o = CMP_GT;
        res_sel_o  = RES_CMP_VEC;
      end
      ALU_GES, ALU_GEU: begin
        cmp_kind_o = CMP_GE;
        res_sel_o  = RES_CMP_VEC;
      end
      ALU_LTS, ALU_LTU: begin
        cmp_kind_o = CMP_LT;
        res_sel_o  = RES_CMP_VEC;
      end
      ALU_LES, ALU_LEU: begin
        cmp_kind_o = CMP_LE;
        res_sel_o  = RES_CMP_VEC;
      end
      // scalar forms only differ in how the result is packed
      ALU_SLTS, ALU_SLTU: begin
        cmp_kind_o = CMP_LT;
        res_sel_o  = RES_CMP_SCALAR;
      end
      ALU_SLETS, ALU_SLETU: begin
        cmp_kind_o = CMP_LE;
        res_sel_o  = RES_CMP_SCALAR;
      end
      ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU, ALU_ABS: res_sel_o = RES_MINMAX;
      ALU_FF1, ALU_FL1, ALU_CNT, ALU_CLB: begin
        res_sel_o = RES_BITCNT;
        if (operator_i == ALU_FF1) bitcnt_kind_o = BC_FF1;
        if (operator_i == ALU_FL1) bitcnt_kind_o = BC_FL1;
        if (operator_i == ALU_CLB) bitcnt_kind_o = BC_CLB;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: source/alu_execute.sv
// combinational datapath, lane layout is taken from lane_break so only the three decoded masks are legal
`timescale 1ns/1ps
`default_nettype none
`include "alu_config.svh"

module alu_execute (
  input  logic [`ALU_XLEN-1:0]       operand_a_i,
  input  logic [`ALU_XLEN-1:0]       operand_b_i,
  input  logic                       adder_negate_i,
  input  logic [`ALU_LANES-1:0]      lane_break_i,
  input  alu_ctrl_pkg::shift_kind_e  shift_kind_i,
  input  logic [`ALU_LANES-1:0]      cmp_signed_i,
  input  alu_ctrl_pkg::cmp_kind_e    cmp_kind_i,
  input  logic                       do_min_i,
  input  logic                       do_abs_i,
  input  alu_ctrl_pkg::bitcnt_kind_e bitcnt_kind_i,
  output logic [`ALU_XLEN-1:0]       add_result_o,
  output logic [`ALU_XLEN-1:0]       shift_result_o,
  output logic [`ALU_XLEN-1:0]       minmax_result_o,
  output logic [`ALU_LANES-1:0]      cmp_lanes_o,
  output logic [`ALU_CNT_W-1:0]      bitcnt_o
);
  import alu_ctrl_pkg::*;

  // one guard bit below every byte
  localparam int unsigned STRIDE  = `ALU_LANE_W + 1;
  localparam int unsigned GUARD_W = STRIDE * `ALU_LANES;

  logic mode8;
  logic mode16;

  // recover the lane width from the carry cuts
  assign mode8  = lane_break_i[1];
  assign mode16 = lane_break_i[2] & ~lane_break_i[1];

  ////////////////////////////////////////
  // lane-split adder
  ////////////////////////////////////////

  logic [`ALU_XLEN-1:0] adder_op_a;
  logic [`ALU_XLEN-1:0] adder_op_b;
  logic [GUARD_W-1:0]   adder_in_a;
  logic [GUARD_W-1:0]   adder_in_b;
  logic [GUARD_W-1:0]   adder_sum;

  // abs runs 0 + ~A + 1
  assign adder_op_a = do_abs_i ? '0 : operand_a_i;
  assign adder_op_b = (do_abs_i ? operand_a_i : operand_b_i) ^ {`ALU_XLEN{adder_negate_i}};

  for (genvar k = 0; k < `ALU_LANES; k++) begin : g_adder
    // 1+0 passes a carry, 0+0 kills it, 1+1 injects the +1 of a negation
    assign adder_in_a[STRIDE*k] = lane_break_i[k] ? adder_negate_i : 1'b1;
    assign adder_in_b[STRIDE*k] = lane_break_i[k] & adder_negate_i;
    assign adder_in_a[STRIDE*k+1 +: `ALU_LANE_W] = adder_op_a[`ALU_LANE_W*k +: `ALU_LANE_W];
    assign adder_in_b[STRIDE*k+1 +: `ALU_LANE_W] = adder_op_b[`ALU_LANE_W*k +: `ALU_LANE_W];
    assign add_result_o[`ALU_LANE_W*k +: `ALU_LANE_W] = adder_sum[STRIDE*k+1 +: `ALU_LANE_W];
  end

  assign adder_sum = adder_in_a + adder_in_b;

  ////////////////////////////////////////
  // lane shifter
  ////////////////////////////////////////

  logic                 shift_left;
  logic                 arith;
  logic [`ALU_XLEN-1:0] a_rev;
  logic [`ALU_XLEN-1:0] shift_op;
  logic [`ALU_XLEN-1:0] shift_amt;
  logic [`ALU_XLEN-1:0] shift_right;
  logic [`ALU_XLEN-1:0] shift_right_rev;

  assign shift_left = (shift_kind_i == SH_LEFT);
  assign arith      = (shift_kind_i == SH_RIGHT_ARITH);

  for (genvar i = 0; i < `ALU_XLEN; i++) begin : g_rev
    assign a_rev[i]           = operand_a_i[`ALU_XLEN-1-i];
    assign shift_right_rev[i] = shift_right[`ALU_XLEN-1-i];
  end

  assign shift_op = shift_left ? a_rev : operand_a_i;

  // reversal also swaps lane order so the amounts follow it
  always_comb begin
    shift_amt = operand_b_i;
    if (shift_left && mode8) begin
      shift_amt = {operand_b_i[7:0], operand_b_i[15:8], operand_b_i[23:16], operand_b_i[31:24]};
    end else if (shift_left && mode16) begin
      shift_amt = {operand_b_i[15:0], operand_b_i[31:16]};
    end
  end

  // sign bit only extends for SRA
  always_comb begin
    shift_right = 32'($signed({arith & shift_op[31], shift_op}) >>> shift_amt[4:0]);
    if (mode8) begin
      for (int k = 0; k < 4; k++) begin
        shift_right[8*k +: 8] = 8'($signed({arith & shift_op[8*k+7], shift_op[8*k +: 8]})
                                   >>> shift_amt[8*k +: 3]);
      end
    end else if (mode16) begin
      for (int k = 0; k < 2; k++) begin
        shift_right[16*k +: 16] = 16'($signed({arith & shift_op[16*k+15], shift_op[16*k +: 16]})
                                     >>> shift_amt[16*k +: 4]);
      end
    end
  end

  assign shift_result_o = shift_left ? shift_right_rev : shift_right;

  ////////////////////////////////////////
  // lane comparator and min/max/abs
  ////////////////////////////////////////

  logic [`ALU_XLEN-1:0]  cmp_b;
  logic [`ALU_LANES-1:0] eq_byte;
  logic [`ALU_LANES-1:0] gt_byte;
  logic [`ALU_LANES-1:0] is_equal;
  logic [`ALU_LANES-1:0] is_greater;
  logic [`ALU_LANES-1:0] sel_a;

  // abs picks the larger of A and -A
  assign cmp_b = do_abs_i ? add_result_o : operand_b_i;

  for (genvar k = 0; k < `ALU_LANES; k++) begin : g_cmp_byte
    assign eq_byte[k] = (operand_a_i[8*k +: 8] == cmp_b[8*k +: 8]);
    // extra top bit makes a signed compare on the sign-carrying byte only
    assign gt_byte[k] = $signed({operand_a_i[8*k+7] & cmp_signed_i[k], operand_a_i[8*k +: 8]}) >
                        $signed({cmp_b[8*k+7] & cmp_signed_i[k], cmp_b[8*k +: 8]});
  end

  // higher byte decides unless equal, result copied into every byte of the lane
  always_comb begin
    is_equal   = {4{&eq_byte}};
    is_greater = {4{gt_byte[3] | (eq_byte[3] & (gt_byte[2] | (eq_byte[2] &
                   (gt_byte[1] | (eq_byte[1] & gt_byte[0])))))}};
    if (mode8) begin
      is_equal   = eq_byte;
      is_greater = gt_byte;
    end else if (mode16) begin
      is_equal   = {{2{&eq_byte[3:2]}}, {2{&eq_byte[1:0]}}};
      is_greater = {{2{gt_byte[3] | (eq_byte[3] & gt_byte[2])}},
                    {2{gt_byte[1] | (eq_byte[1] & gt_byte[0])}}};
    end
  end

  always_comb begin
    case (cmp_kind_i)
      CMP_NE:  cmp_lanes_o = ~is_equal;
      CMP_GT:  cmp_lanes_o = is_greater;
      CMP_GE:  cmp_lanes_o = is_greater | is_equal;
      CMP_LT:  cmp_lanes_o = ~(is_greater | is_equal);
      CMP_LE:  cmp_lanes_o = ~is_greater;
      default: cmp_lanes_o = is_equal;
    endcase
  end

  assign sel_a = is_greater ^ {`ALU_LANES{do_min_i}};

  for (genvar k = 0; k < `ALU_LANES; k++) begin : g_minmax
    assign minmax_result_o[8*k +: 8] = sel_a[k] ? operand_a_i[8*k +: 8] : cmp_b[8*k +: 8];
  end

  alu_bitcount u_bitcount (
    .operand_a_i   (operand_a_i),
    .bitcnt_kind_i (bitcnt_kind_i),
    .bitcnt_o      (bitcnt_o)
  );

endmodule

`default_nettype wire

// File: source/alu_result.sv
// the only register stage, result and compare flag hold while enable_i is low
`timescale 1ns/1ps
`default_nettype none
`include "alu_config.svh"

module alu_result (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   enable_i,
  input  alu_ctrl_pkg::res_sel_e res_sel_i,
  input  logic [`ALU_XLEN-1:0]   operand_a_i,
  input  logic [`ALU_XLEN-1:0]   operand_b_i,
  input  logic [`ALU_XLEN-1:0]   add_result_i,
  input  logic [`ALU_XLEN-1:0]   shift_result_i,
  input  logic [`ALU_XLEN-1:0]   minmax_result_i,
  input  logic [`ALU_LANES-1:0]  cmp_lanes_i,
  input  logic [`ALU_CNT_W-1:0]  bitcnt_i,
  output logic [`ALU_XLEN-1:0]   result_o,
  output logic                   comparison_result_o,
  output logic                   valid_o
);
  import alu_ctrl_pkg::*;

  logic [`ALU_XLEN-1:0] cmp_vec;
  logic [`ALU_XLEN-1:0] result_d;

  // each lane flag fills its byte
  for (genvar k = 0; k < `ALU_LANES; k++) begin : g_cmp_vec
    assign cmp_vec[`ALU_LANE_W*k +: `ALU_LANE_W] = {`ALU_LANE_W{cmp_lanes_i[k]}};
  end

  always_comb begin
    case (res_sel_i)
      RES_OR:         result_d = operand_a_i | operand_b_i;
      RES_XOR:        result_d = operand_a_i ^ operand_b_i;
      RES_ADD:        result_d = add_result_i;
      RES_SHIFT:      result_d = shift_result_i;
      RES_CMP_VEC:    result_d = cmp_vec;
      // top lane only
      RES_CMP_SCALAR: result_d = {{(`ALU_XLEN-1){1'b0}}, cmp_lanes_i[`ALU_LANES-1]};
      RES_MINMAX:     result_d = minmax_result_i;
      RES_BITCNT:     result_d = {{(`ALU_XLEN-`ALU_CNT_W){1'b0}}, bitcnt_i};
      default:        result_d = operand_a_i & operand_b_i;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o             <= 1'b0;
      result_o            <= '0;
      comparison_result_o <= 1'b0;
    end else begin
      valid_o <= enable_i;
      if (enable_i) begin
        result_o            <= result_d;
        comparison_result_o <= cmp_lanes_i[`ALU_LANES-1];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/alu_top.sv
// one op per cycle with a fixed latency of one cycle and no back-pressure
`timescale 1ns/1ps
`default_nettype none
`include "alu_config.svh"

module alu_top (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  enable_i,
  input  alu_op_pkg::alu_op_e   operator_i,
  input  alu_op_pkg::vec_mode_e vector_mode_i,
  input  logic [`ALU_XLEN-1:0]  operand_a_i,
  input  logic [`ALU_XLEN-1:0]  operand_b_i,
  output logic [`ALU_XLEN-1:0]  result_o,
  output logic                  comparison_result_o,
  output logic                  valid_o
);
  import alu_ctrl_pkg::*;

  // decode to execute
  logic                  adder_negate;
  logic [`ALU_LANES-1:0] lane_break;
  shift_kind_e           shift_kind;
  logic [`ALU_LANES-1:0] cmp_signed;
  cmp_kind_e             cmp_kind;
  logic                  do_min;
  logic                  do_abs;
  bitcnt_kind_e          bitcnt_kind;
  res_sel_e              res_sel;

  // execute to result
  logic [`ALU_XLEN-1:0]  add_result;
  logic [`ALU_XLEN-1:0]  shift_result;
  logic [`ALU_XLEN-1:0]  minmax_result;
  logic [`ALU_LANES-1:0] cmp_lanes;
  logic [`ALU_CNT_W-1:0] bitcnt_result;

  alu_decode u_decode (
    .operator_i     (operator_i),
    .vector_mode_i  (vector_mode_i),
    .adder_negate_o (adder_negate),
    .lane_break_o   (lane_break),
    .shift_kind_o   (shift_kind),
    .cmp_signed_o   (cmp_signed),
    .cmp_kind_o     (cmp_kind),
    .do_min_o       (do_min),
    .do_abs_o       (do_abs),
    .bitcnt_kind_o  (bitcnt_kind),
    .res_sel_o      (res_sel)
  );

  alu_execute u_execute (
    .operand_a_i     (operand_a_i),
    .operand_b_i     (operand_b_i),
    .adder_negate_i  (adder_negate),
    .lane_break_i    (lane_break),
    .shift_kind_i    (shift_kind),
    .cmp_signed_i    (cmp_signed),
    .cmp_kind_i      (cmp_kind),
    .do_min_i        (do_min),
    .do_abs_i        (do_abs),
    .bitcnt_kind_i   (bitcnt_kind),
    .add_result_o    (add_result),
    .shift_result_o  (shift_result),
    .minmax_result_o (minmax_result),
    .cmp_lanes_o     (cmp_lanes),
    .bitcnt_o        (bitcnt_result)
  );

  alu_result u_result (
    .clk                 (clk),
    .rst_n_i             (rst_n_i),
    .enable_i            (enable_i),
    .res_sel_i           (res_sel),
    .operand_a_i         (operand_a_i),
    .operand_b_i         (operand_b_i),
    .add_result_i        (add_result),
    .shift_result_i      (shift_result),
    .minmax_result_i     (minmax_result),
    .cmp_lanes_i         (cmp_lanes),
    .bitcnt_i            (bitcnt_result),
    .result_o            (result_o),
    .comparison_result_o (comparison_result_o),
    .valid_o             (valid_o)
  );

endmodule

`default_nettype wire

// File: sim/alu_props.sv
// expects one clock and a fixed one-cycle result latency and samples outputs at the falling edge
`timescale 1ns/1ps
`default_nettype none
`include "alu_config.svh"

module alu_props (
  input logic                  clk,
  input logic                  rst_n_i,
  input logic                  enable_i,
  input alu_op_pkg::alu_op_e   operator_i,
  input alu_op_pkg::vec_mode_e vector_mode_i,
  input logic [`ALU_XLEN-1:0]  operand_a_i,
  input logic [`ALU_XLEN-1:0]  operand_b_i,
  input logic [`ALU_XLEN-1:0]  result_i,
  input logic                  cmp_result_i,
  input logic                  valid_i
);
  import alu_op_pkg::*;

  // failed checks, read by the testbench at the end of the run
  int error_count = 0;

  logic                 en_q;
  alu_op_e              op_q;
  vec_mode_e            mode_q;
  logic [`ALU_XLEN-1:0] a_q;
  logic [`ALU_XLEN-1:0] b_q;
  logic [`ALU_XLEN-1:0] exp_result;
  logic                 exp_cmp;
  logic                 is_cmp_op;

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic int lane_width(vec_mode_e m);
    case (m)
      VEC_MODE16: return 16;
      VEC_MODE8:  return 8;
      default:    return 32;
    endcase
  endfunction

  // lane value read as two's complement
  function automatic longint sext(longint v, int w);
    return (v >= (64'sd1 <<< (w - 1))) ? v - (64'sd1 <<< w) : v;
  endfunction

  // relation of one lane pair for any compare opcode
  function automatic bit lane_rel(alu_op_e op, longint ua, longint ub, int w);
    longint sa;
    longint sb;
    bit     rel;
    sa  = sext(ua, w);
    sb  = sext(ub, w);
    rel = 1'b0;
    case (op)
      ALU_EQ:               rel = (ua == ub);
      ALU_NE:               rel = (ua != ub);
      ALU_GTS:              rel = (sa > sb);
      ALU_GTU:              rel = (ua > ub);
      ALU_GES:              rel = (sa >= sb);
      ALU_GEU:              rel = (ua >= ub);
      ALU_LTS, ALU_SLTS:    rel = (sa < sb);
      ALU_LTU, ALU_SLTU:    rel = (ua < ub);
      ALU_LES, ALU_SLETS:   rel = (sa <= sb);
      ALU_LEU, ALU_SLETU:   rel = (ua <= ub);
      default:              rel = 1'b0;
    endcase
    return rel;
  endfunction

  // the top lane is the most significant w bits of the word
  function automatic bit top_rel(alu_op_e op, vec_mode_e m, logic [31:0] a, logic [31:0] b);
    int w;
    w = lane_width(m);
    return lane_rel(op, longint'(a >> (32 - w)), longint'(b >> (32 - w)), w);
  endfunction

  function automatic int bit_count(alu_op_e op, logic [31:0] a);
    int n;
    n = 0;
    case (op)
      ALU_CNT: begin
        for (int i = 0; i < 32; i++) n = n + int'(a[i]);
      end
      ALU_FF1: begin
        n = 32;
        for (int i = 31; i >= 0; i--) if (a[i]) n = i;
      end
      ALU_FL1: begin
        n = 32;
        for (int i = 0; i < 32; i++) if (a[i]) n = i;
      end
      default: begin
        // leading copies of the sign bit less one, zero stays 0
        if (a != '0) begin
          for (int i = 31; i >= 0; i--) begin
            if (a[i] != a[31]) break;
            n = n + 1;
          end
          n = n - 1;
        end
      end
    endcase
    return n;
  endfunction

  function automatic logic [31:0] ref_result(alu_op_e op, vec_mode_e m,
                                             logic [31:0] a, logic [31:0] b);
    int          w;
    int          sh;
    longint      mask;
    longint      ua;
    longint      ub;
    longint      r;
    logic [31:0] res;
    w    = lane_width(m);
    mask = (64'sd1 <<< w) - 1;
    res  = '0;
    for (int i = 0; i < 32 / w; i++) begin
      ua = longint'(a >> (i * w)) & mask;
      ub = longint'(b >> (i * w)) & mask;
      // shift amount is the low log2(w) bits of the lane of B
      sh = int'(ub) & (w - 1);
      case (op)
        ALU_ADD:  r = ua + ub;
        ALU_SUB:  r = ua - ub;
        ALU_SLL:  r = ua << sh;
        ALU_SRL:  r = ua >> sh;
        ALU_SRA:  r = sext(ua, w) >>> sh;
        ALU_MIN:  r = (sext(ua, w) < sext(ub, w)) ? ua : ub;
        ALU_MINU: r = (ua < ub) ? ua : ub;
        ALU_MAX:  r = (sext(ua, w) > sext(ub, w)) ? ua : ub;
        ALU_MAXU: r = (ua > ub) ? ua : ub;
        ALU_ABS:  r = (sext(ua, w) < 0) ? -sext(ua, w) : ua;
        default:  r = lane_rel(op, ua, ub, w) ? mask : 0;
      endcase
      res = res | (32'(r & mask) << (i * w));
    end
    // whole-word ops replace the lane result
    case (op)
      ALU_AND: res = a & b;
      ALU_OR:  res = a | b;
      ALU_XOR: res = a ^ b;
      ALU_SLTS, ALU_SLTU, ALU_SLETS, ALU_SLETU: res = 32'(top_rel(op, m, a, b));
      ALU_FF1, ALU_FL1, ALU_CNT, ALU_CLB:       res = 32'(bit_count(op, a));
      default: ;
    endcase
    return res;
  endfunction

  ////////////////////////////////////////
  // issued op and expected response
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q   <= 1'b0;
      op_q   <= ALU_ADD;
      mode_q <= VEC_MODE32;
      a_q    <= '0;
      b_q    <= '0;
    end else begin
      en_q <= enable_i;
      if (enable_i) begin
        op_q   <= operator_i;
        mode_q <= vector_mode_i;
        a_q    <= operand_a_i;
        b_q    <= operand_b_i;
      end
    end
  end

  always_comb begin
    exp_result = ref_result(op_q, mode_q, a_q, b_q);
    exp_cmp    = top_rel(op_q, mode_q, a_q, b_q);
    is_cmp_op  = op_q inside {ALU_EQ, ALU_NE, ALU_GTS, ALU_GTU, ALU_GES, ALU_GEU, ALU_LTS,
                              ALU_LTU, ALU_LES, ALU_LEU, ALU_SLTS, ALU_SLTU, ALU_SLETS,
                              ALU_SLETU};
  end

  // all outputs read zero while reset is held
  reset_values: assert property (@(negedge clk)
    !rst_n_i |-> (valid_i == 1'b0 && result_i == '0 && cmp_result_i == 1'b0))
    else begin
      $error("[ERROR] reset: expected valid=0 result=00000000 cmp=0, actual valid=%0b result=%h cmp=%0b",
             valid_i, result_i, cmp_result_i);
      error_count++;
    end

  valid_strobe: assert property (@(negedge clk) disable iff (!rst_n_i) valid_i == en_q)
    else begin
      $error("[ERROR] valid: expected %0b, actual %0b", en_q, valid_i);
      error_count++;
    end

  result_value: assert property (@(negedge clk) disable iff (!rst_n_i)
    en_q |-> result_i == exp_result)
    else begin
      $error("[ERROR] %s: expected %h, actual %h", op_q.name(), exp_result, result_i);
      error_count++;
    end

  // top lane relation for every compare opcode
  cmp_value: assert property (@(negedge clk) disable iff (!rst_n_i)
    (en_q && is_cmp_op) |-> cmp_result_i == exp_cmp)
    else begin
      $error("[ERROR] %s compare flag: expected %0b, actual %0b", op_q.name(), exp_cmp,
             cmp_result_i);
      error_count++;
    end

  result_hold: assert property (@(negedge clk) disable iff (!rst_n_i)
    !en_q |-> $stable(result_i))
    else begin
      $error("result_o changed in a cycle with no op issued");
      error_count++;
    end

endmodule

`default_nettype wire

// File: sim/alu_tb.sv
// drives alu_top 2 ns after each rising edge and leaves all checking to the bound alu_props
`timescale 1ns/1ps
`default_nettype none
`include "alu_config.svh"

module alu_tb;
  import alu_op_pkg::*;
  import alu_ctrl_pkg::*;

  localparam int RESET_CYCLES    = 16;
  localparam int DIRECTED_CYCLES = 50;
  localparam int RANDOM_CYCLES   = 400;
  localparam int MARGIN_CYCLES   = 50;
  localparam int CYCLE_LIMIT     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES;

  logic                 clk;
  logic                 rst_n;
  logic                 enable;
  alu_op_e              op;
  vec_mode_e            vec_mode;
  logic [`ALU_XLEN-1:0] operand_a;
  logic [`ALU_XLEN-1:0] operand_b;
  logic [`ALU_XLEN-1:0] result;
  logic                 cmp_result;
  logic                 valid;
  int                   cycle_count = 0;

  bind alu_top alu_props u_props (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .enable_i      (enable_i),
    .operator_i    (operator_i),
    .vector_mode_i (vector_mode_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .result_i      (result_o),
    .cmp_result_i  (comparison_result_o),
    .valid_i       (valid_o)
  );

  alu_top uut (
    .clk                 (clk),
    .rst_n_i             (rst_n),
    .enable_i            (enable),
    .operator_i          (op),
    .vector_mode_i       (vec_mode),
    .operand_a_i         (operand_a),
    .operand_b_i         (operand_b),
    .result_o            (result),
    .comparison_result_o (cmp_result),
    .valid_o             (valid)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // present one op for one cycle
  task automatic issue(input alu_op_e o, input vec_mode_e m, input logic [31:0] a,
                       input logic [31:0] b);
    @(posedge clk);
    #2;
    enable    = 1'b1;
    op        = o;
    vec_mode  = m;
    operand_a = a;
    operand_b = b;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
      enable = 1'b0;
    end
  endtask

  ////////////////////////////////////////
  // directed corner cases
  ////////////////////////////////////////

  task automatic run_directed();
    vec_mode_e   modes[3];
    alu_op_e     lane_ops[6];
    logic [31:0] lane_a[6];
    logic [31:0] lane_b[6];
    alu_op_e     cnt_ops[4];
    logic [31:0] cnt_a[5];
    modes    = '{VEC_MODE32, VEC_MODE16, VEC_MODE8};
    // operands chosen so carries, borrows and sign bits cross lane borders
    lane_ops = '{ALU_ADD, ALU_SUB, ALU_SRA, ALU_SLL, ALU_GTS, ALU_ABS};
    lane_a   = '{32'h7fff_80ff, 32'h0000_0000, 32'h8080_8080, 32'h8181_8181,
                 32'h80ff_7f00, 32'h8000_8080};
    lane_b   = '{32'h0001_8001, 32'h0101_0101, 32'h0707_0f1f, 32'h0103_0507,
                 32'h7f00_8001, 32'h0000_0000};
    cnt_ops  = '{ALU_FF1, ALU_FL1, ALU_CNT, ALU_CLB};
    // zero, all ones and single set bits
    cnt_a    = '{32'h0000_0000, 32'hffff_ffff, 32'h0000_0001, 32'h0001_0000, 32'h8000_0000};
    foreach (modes[m]) begin
      for (int i = 0; i < 6; i++) issue(lane_ops[i], modes[m], lane_a[i], lane_b[i]);
    end
    idle(1);
    issue(ALU_AND, VEC_MODE32, 32'hf0f0_3c3c, 32'hff00_0ff0);
    issue(ALU_OR, VEC_MODE32, 32'hf0f0_3c3c, 32'hff00_0ff0);
    issue(ALU_XOR, VEC_MODE32, 32'hf0f0_3c3c, 32'hff00_0ff0);
    issue(ALU_EQ, VEC_MODE32, 32'h1234_5678, 32'h1234_5678);
    issue(ALU_NE, VEC_MODE32, 32'h1234_5678, 32'h1234_5679);
    // -1 against 1 flips between signed and unsigned
    issue(ALU_SLTS, VEC_MODE32, 32'hffff_ffff, 32'h0000_0001);
    issue(ALU_SLTU, VEC_MODE32, 32'hffff_ffff, 32'h0000_0001);
    issue(ALU_SLETS, VEC_MODE32, 32'h8000_0000, 32'h8000_0000);
    issue(ALU_SLETU, VEC_MODE32, 32'h0000_0001, 32'h0000_0000);
    idle(1);
    foreach (cnt_ops[k]) begin
      foreach (cnt_a[i]) issue(cnt_ops[k], VEC_MODE32, cnt_a[i], 32'h0000_0000);
    end
  endtask

  // reset lands right after an equal compare so all three outputs are nonzero when it hits
  // enable stays high through the pulse
  task automatic reset_mid_run();
    issue(ALU_EQ, VEC_MODE32, 32'h5a5a_5a5a, 32'h5a5a_5a5a);
    @(posedge clk);
    #2;
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
  endtask

  ////////////////////////////////////////
  // random ops with occasional idle cycles
  ////////////////////////////////////////

  task automatic run_random();
    alu_op_e   all_ops[31];
    vec_mode_e modes[3];
    all_ops = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
                ALU_EQ, ALU_NE, ALU_GTS, ALU_GTU, ALU_GES, ALU_GEU, ALU_LTS, ALU_LTU,
                ALU_LES, ALU_LEU, ALU_SLTS, ALU_SLTU, ALU_SLETS, ALU_SLETU, ALU_MIN,
                ALU_MINU, ALU_MAX, ALU_MAXU, ALU_ABS, ALU_FF1, ALU_FL1, ALU_CNT, ALU_CLB};
    modes   = '{VEC_MODE32, VEC_MODE16, VEC_MODE8};
    repeat (RANDOM_CYCLES) begin
      @(posedge clk);
      #2;
      enable    = ($urandom_range(0, 7) != 0);
      op        = all_ops[$urandom_range(0, 30)];
      vec_mode  = modes[$urandom_range(0, 2)];
      operand_a = $urandom();
      // equal operands now and then so equality is reached
      operand_b = ($urandom_range(0, 7) == 0) ? operand_a : $urandom();
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles with the test still running, %0d errors",
               CYCLE_LIMIT, uut.u_props.error_count);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h9960_ec5b));
    rst_n     = 1'b0;
    enable    = 1'b0;
    op        = ALU_ADD;
    vec_mode  = VEC_MODE32;
    operand_a = '0;
    operand_b = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    run_directed();
    reset_mid_run();
    run_random();
    // last result is checked at the next falling edge
    idle(3);
    $display("closing summary: %0d errors", uut.u_props.error_count);
    if (uut.u_props.error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: alu_top.f
+incdir+source
source/alu_op_pkg.sv
source/alu_ctrl_pkg.sv
source/alu_bitcount.sv
source/alu_decode.sv
source/alu_execute.sv
source/alu_result.sv
source/alu_top.sv
sim/alu_props.sv
sim/alu_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the ALU testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f alu_top.f --top-module alu_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

# a high error limit lets every failing check be counted before the run ends
sim_out=$(./obj_dir/Valu_tb +verilator+error+limit+100000)
status=$?
printf '%s\n' "$sim_out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Result: PASSED"; then
  exit 0
fi
echo "simulation did not report a pass"
exit 1
